/* cpu_pkg.sv */
package cpu_pkg;

    // datapath and address width
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // first instruction address after reset
    localparam logic [xlen-1:0] default_reset_vector = 32'h1c00_0000;
    localparam logic [xlen-1:0] inst_bytes           = 32'd4;

    // major opcode, inst[31:26]
    localparam logic [5:0] op6_alu   = 6'h00;
    localparam logic [5:0] op6_lu12i = 6'h05;
    localparam logic [5:0] op6_mem   = 6'h0a;
    localparam logic [5:0] op6_b     = 6'h14;
    localparam logic [5:0] op6_beq   = 6'h16;
    localparam logic [5:0] op6_bne   = 6'h17;

    // inst[25:22] under op6_alu / op6_mem
    localparam logic [3:0] op4_3r   = 4'h0;
    localparam logic [3:0] op4_addi = 4'ha;
    localparam logic [3:0] op4_ldw  = 4'h2;
    localparam logic [3:0] op4_stw  = 4'h6;

    // inst[21:20] for the 3-register group
    localparam logic [1:0] op2_3r = 2'h1;

    // inst[19:15] selects the 3-register operation
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_lui
    } alu_op_t;

    // decode input, instruction word straight from the sram
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_t               alu_op;
        logic [xlen-1:0]       rj_value;
        // rk, or rd for st.w / beq / bne
        logic [xlen-1:0]       rkd_value;
        logic [xlen-1:0]       imm;
        // already shifted left by 2
        logic [xlen-1:0]       br_offs;
        logic                  src2_is_imm;
        logic                  res_from_mem;
        logic                  rf_we;
        logic                  mem_we;
        logic                  is_beq;
        logic                  is_bne;
        logic                  is_b;
        logic [reg_addr_w-1:0] dest;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       alu_result;
        logic                  res_from_mem;
        logic                  rf_we;
        logic [reg_addr_w-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        ex_mem_t         ex;
        logic [xlen-1:0] load_data;
    } mem_wb_t;

    // branch outcome from execute
    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

/* dmem_if.sv */
interface dmem_if #(
    parameter int width = 32
);

    logic             we;
    logic [width-1:0] addr;
    logic [width-1:0] wdata;
    // valid one cycle after addr
    logic [width-1:0] rdata;

    modport req (output we, output addr, output wdata);
    modport rsp (input rdata);
    modport mem (input we, input addr, input wdata, output rdata);

endinterface

/* regfile.sv */
module regfile import cpu_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous read with no bypass from the write port
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a write aimed at r0 leaves the r0 storage untouched
    r0_write_ignored: assert property (@(posedge clk)
        we && waddr == '0 |=> regs[0] === $past(regs[0]));

endmodule

/* alu.sv */
module alu import cpu_pkg::*; (
    input  alu_op_t         alu_op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            lt_signed;
    logic            lt_unsigned;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // signed compare from sign bits and the difference
    assign lt_signed   = (src1[xlen-1] & ~src2[xlen-1])
                       | (~(src1[xlen-1] ^ src2[xlen-1]) & diff[xlen-1]);
    assign lt_unsigned = (src1 < src2);

    always_comb begin
        case (alu_op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            // upper immediate already placed by decode
            alu_lui:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

/* fetch_stage.sv */
module fetch_stage import cpu_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = default_reset_vector
) (
    input  logic            clk,
    input  logic            reset,
    input  redirect_t       redirect,
    output logic [xlen-1:0] inst_sram_addr,
    input  logic [xlen-1:0] inst_sram_rdata,
    output if_id_t          if_id,
    output logic            if_valid
);

    // pc of the word now on inst_sram_rdata
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;

    // taken branch replaces the sequential request in the same cycle,
    // so the wrong-path word after the one in decode is never fetched
    assign next_pc        = redirect.taken ? redirect.target : pc + inst_bytes;
    assign inst_sram_addr = next_pc;

    // pc and valid form the fetch-to-decode register, the sram holds the word
    always_ff @(posedge clk) begin
        if (reset) begin
            // one word below, next_pc is then the reset vector
            pc       <= reset_vector - inst_bytes;
            if_valid <= 1'b0;
        end else begin
            pc       <= next_pc;
            if_valid <= 1'b1;
        end
    end

    assign if_id.pc   = pc;
    assign if_id.inst = inst_sram_rdata;

    // word aligned requests only
    addr_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_sram_addr[1:0] == 2'b00);

endmodule

/* decode_stage.sv */
module decode_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  if_id_t                if_id,
    input  logic                  if_valid,
    input  redirect_t             redirect,
    input  logic                  rf_we,
    input  logic [reg_addr_w-1:0] rf_waddr,
    input  logic [xlen-1:0]       rf_wdata,
    output id_ex_t                id_ex,
    output logic                  id_valid
);

    logic [xlen-1:0]       inst;
    logic [5:0]            op6;
    logic [3:0]            op4;
    logic [1:0]            op2;
    logic [4:0]            op5;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [11:0]           i12;
    logic [19:0]           i20;
    logic [15:0]           i16;
    logic [25:0]           i26;

    logic is_3r;
    logic inst_add, inst_sub, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_addi, inst_lu12i, inst_ldw, inst_stw;
    logic inst_beq, inst_bne, inst_b;
    logic known;

    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    id_ex_t                dec;

    assign inst = if_id.inst;
    assign op6  = inst[31:26];
    assign op4  = inst[25:22];
    assign op2  = inst[21:20];
    assign op5  = inst[19:15];
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign i12  = inst[21:10];
    assign i20  = inst[24:5];
    assign i16  = inst[25:10];
    // b keeps the high offset bits in [9:0]
    assign i26  = {inst[9:0], inst[25:10]};

    // 3-register ops share op6, op4 and op2
    assign is_3r     = (op6 == op6_alu) && (op4 == op4_3r) && (op2 == op2_3r);
    assign inst_add  = is_3r && (op5 == op5_add);
    assign inst_sub  = is_3r && (op5 == op5_sub);
    assign inst_slt  = is_3r && (op5 == op5_slt);
    assign inst_sltu = is_3r && (op5 == op5_sltu);
    assign inst_nor  = is_3r && (op5 == op5_nor);
    assign inst_and  = is_3r && (op5 == op5_and);
    assign inst_or   = is_3r && (op5 == op5_or);
    assign inst_xor  = is_3r && (op5 == op5_xor);

    assign inst_addi  = (op6 == op6_alu) && (op4 == op4_addi);
    assign inst_ldw   = (op6 == op6_mem) && (op4 == op4_ldw);
    assign inst_stw   = (op6 == op6_mem) && (op4 == op4_stw);
    assign inst_lu12i = (op6 == op6_lu12i) && !inst[25];
    assign inst_b     = (op6 == op6_b);
    assign inst_beq   = (op6 == op6_beq);
    assign inst_bne   = (op6 == op6_bne);

    // anything else turns into a bubble
    assign known = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_addi | inst_lu12i | inst_ldw | inst_stw
                 | inst_b | inst_beq | inst_bne;

    // stores and compares read rd on port 2
    assign raddr2 = (inst_stw | inst_beq | inst_bne) ? rd : rk;

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    always_comb begin
        dec.pc        = if_id.pc;
        dec.rj_value  = rdata1;
        dec.rkd_value = rdata2;
        // address ops use the adder
        if (inst_sub) dec.alu_op = alu_sub;
        else if (inst_slt) dec.alu_op = alu_slt;
        else if (inst_sltu) dec.alu_op = alu_sltu;
        else if (inst_and) dec.alu_op = alu_and;
        else if (inst_nor) dec.alu_op = alu_nor;
        else if (inst_or) dec.alu_op = alu_or;
        else if (inst_xor) dec.alu_op = alu_xor;
        else if (inst_lu12i) dec.alu_op = alu_lui;
        else dec.alu_op = alu_add;
        // si20 lands in the upper bits, else sign-extended si12
        dec.imm = inst_lu12i ? {i20, 12'b0} : {{20{i12[11]}}, i12};
        dec.br_offs = inst_b ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
        dec.src2_is_imm  = inst_addi | inst_lu12i | inst_ldw | inst_stw;
        dec.res_from_mem = inst_ldw;
        dec.rf_we        = known & ~inst_stw & ~inst_beq & ~inst_bne & ~inst_b;
        dec.mem_we       = inst_stw;
        dec.is_beq       = inst_beq;
        dec.is_bne       = inst_bne;
        dec.is_b         = inst_b;
        dec.dest         = rd;
    end

    always_ff @(posedge clk) begin
        id_ex <= dec;
    end

    // taken branch in execute kills the instruction decoded behind it
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid && known && !redirect.taken;
        end
    end

endmodule

/* execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  id_ex_t    id_ex,
    input  logic      id_valid,
    dmem_if.req       dmem,
    output redirect_t redirect,
    output ex_mem_t   ex_mem,
    output logic      ex_valid
);

    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic            rj_eq_rkd;
    ex_mem_t         ex_next;

    assign src2 = id_ex.src2_is_imm ? id_ex.imm : id_ex.rkd_value;

    alu alu_inst (
        .alu_op (id_ex.alu_op),
        .src1   (id_ex.rj_value),
        .src2   (src2),
        .result (alu_result)
    );

    // branch resolution
    assign rj_eq_rkd       = (id_ex.rj_value == id_ex.rkd_value);
    assign redirect.taken  = id_valid && ((id_ex.is_beq && rj_eq_rkd)
                                       || (id_ex.is_bne && !rj_eq_rkd)
                                       || id_ex.is_b);
    assign redirect.target = id_ex.pc + id_ex.br_offs;

    // address from the adder, store data from rd
    assign dmem.we    = id_valid && id_ex.mem_we;
    assign dmem.addr  = alu_result;
    assign dmem.wdata = id_ex.rkd_value;

    assign ex_next.pc           = id_ex.pc;
    assign ex_next.alu_result   = alu_result;
    assign ex_next.res_from_mem = id_ex.res_from_mem;
    assign ex_next.rf_we        = id_ex.rf_we;
    assign ex_next.dest         = id_ex.dest;

    always_ff @(posedge clk) begin
        ex_mem <= ex_next;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    // stores only issue from a live store
    store_needs_valid: assert property (@(posedge clk) disable iff (reset)
        dmem.we |-> id_valid && !id_ex.rf_we);

    // taken redirect comes from a branch, and decode drops the next slot
    redirect_from_branch: assert property (@(posedge clk) disable iff (reset)
        redirect.taken |-> (id_ex.is_beq || id_ex.is_bne || id_ex.is_b) ##1 !id_valid);

endmodule

/* writeback_stage.sv */
module writeback_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  ex_mem_t               ex_mem,
    input  logic                  ex_valid,
    dmem_if.rsp                   dmem,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic                  debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    mem_wb_t         mem_wb;
    logic            wb_valid;
    logic [xlen-1:0] final_result;

    // memory stage, rdata belongs to the address sent from execute
    always_ff @(posedge clk) begin
        mem_wb.ex        <= ex_mem;
        mem_wb.load_data <= dmem.rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    assign final_result = mem_wb.ex.res_from_mem ? mem_wb.load_data : mem_wb.ex.alu_result;

    assign rf_we    = wb_valid && mem_wb.ex.rf_we;
    assign rf_waddr = mem_wb.ex.dest;
    assign rf_wdata = final_result;

    // trace follows the register write
    assign debug_wb_pc       = mem_wb.ex.pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* cpu_core.sv */
module cpu_core import cpu_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = default_reset_vector
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic [xlen-1:0]       inst_sram_addr,
    input  logic [xlen-1:0]       inst_sram_rdata,
    output logic                  data_sram_we,
    output logic [xlen-1:0]       data_sram_addr,
    output logic [xlen-1:0]       data_sram_wdata,
    input  logic [xlen-1:0]       data_sram_rdata,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic                  debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    if_id_t                if_id;
    logic                  if_valid;
    id_ex_t                id_ex;
    logic                  id_valid;
    ex_mem_t               ex_mem;
    logic                  ex_valid;
    redirect_t             redirect;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    dmem_if #(.width(xlen)) dmem ();

    // data sram side of the interface
    assign data_sram_we    = dmem.we;
    assign data_sram_addr  = dmem.addr;
    assign data_sram_wdata = dmem.wdata;
    assign dmem.rdata      = data_sram_rdata;

    fetch_stage #(.reset_vector(reset_vector)) fetch_inst (
        .clk             (clk),
        .reset           (reset),
        .redirect        (redirect),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .if_id           (if_id),
        .if_valid        (if_valid)
    );

    decode_stage decode_inst (
        .clk      (clk),
        .reset    (reset),
        .if_id    (if_id),
        .if_valid (if_valid),
        .redirect (redirect),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .id_ex    (id_ex),
        .id_valid (id_valid)
    );

    execute_stage execute_inst (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .id_valid (id_valid),
        .dmem     (dmem.req),
        .redirect (redirect),
        .ex_mem   (ex_mem),
        .ex_valid (ex_valid)
    );

    // memory and writeback stages
    writeback_stage writeback_inst (
        .clk               (clk),
        .reset             (reset),
        .ex_mem            (ex_mem),
        .ex_valid          (ex_valid),
        .dmem              (dmem.rsp),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* tb_cpu_core.sv */
module tb_cpu_core;

    localparam logic [31:0] reset_vector = 32'h1c00_0000;
    // the program retires in well under this many cycles
    localparam int max_cycles = 500;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // program image, quiet marks words that must never trace
    logic [31:0] rom [0:127];
    logic        quiet [0:127];
    int          prog_len;
    logic [31:0] ram [0:63];
    logic [31:0] iaddr_q;
    logic [31:0] daddr_q;

    // expected trace entries and stores in program order
    logic [31:0] exp_pc [0:127];
    logic [4:0]  exp_wnum [0:127];
    logic [31:0] exp_wdata [0:127];
    logic [31:0] exp_saddr [0:7];
    logic [31:0] exp_sdata [0:7];
    int          trace_count;
    int          trace_idx;
    int          store_count;
    int          store_idx;

    int          errors;
    int          cycle;
    int          waited;

    logic [31:0] want_pc;
    logic [4:0]  want_wnum;
    logic [31:0] want_wdata;
    logic [31:0] want_saddr;
    logic [31:0] want_sdata;
    logic [31:0] wb_index;
    logic        wb_quiet;

    cpu_core #(.reset_vector(reset_vector)) cpu_core_inst (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #10 clk = ~clk;

    // 3-register group, op5 picks the operation
    function automatic logic [31:0] rrr_inst(input logic [4:0] op5, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [4:0] rk);
        rrr_inst = {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rj,
                                              input logic [11:0] si12);
        addi_inst = {6'h00, 4'ha, si12, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_inst(input logic [4:0] rd, input logic [19:0] si20);
        lu12i_inst = {7'b0001010, si20, rd};
    endfunction

    // ld.w when store is 0, st.w when 1
    function automatic logic [31:0] ldst_inst(input logic store, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] si12);
        ldst_inst = {6'h0a, (store ? 4'h6 : 4'h2), si12, rj, rd};
    endfunction

    // beq is 6'h16, bne 6'h17, offset counted in words
    function automatic logic [31:0] cond_branch_inst(input logic [5:0] op6, input logic [4:0] rj,
                                                     input logic [4:0] rd, input logic [15:0] offs);
        cond_branch_inst = {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] b_inst(input logic [25:0] offs);
        b_inst = {6'h14, offs[15:0], offs[25:16]};
    endfunction

    // outside the program the rom answers with a branch to itself
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - reset_vector;
        if (offs[1:0] == 2'b00 && (offs >> 2) < prog_len) begin
            rom_word = rom[offs >> 2];
        end else begin
            rom_word = b_inst(26'd0);
        end
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        errors = errors + 1;
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic raise_fault(input string what);
        errors = errors + 1;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic put(input logic [31:0] word, input logic silent);
        rom[prog_len]   = word;
        quiet[prog_len] = silent;
        prog_len        = prog_len + 1;
    endtask

    // instruction that must show up on the trace port
    task automatic alu_write(input logic [31:0] word, input logic [4:0] wnum,
                             input logic [31:0] wdata);
        exp_pc[trace_count]    = reset_vector + 4 * prog_len;
        exp_wnum[trace_count]  = wnum;
        exp_wdata[trace_count] = wdata;
        trace_count            = trace_count + 1;
        put(word, 1'b0);
    endtask

    task automatic store_write(input logic [31:0] word, input logic [31:0] addr,
                               input logic [31:0] data);
        exp_saddr[store_count] = addr;
        exp_sdata[store_count] = data;
        store_count            = store_count + 1;
        put(word, 1'b1);
    endtask

    // addi.w r0, r0, 0 still traces a write to r0
    task automatic nops(input int n);
        for (int i = 0; i < n; i++) begin
            alu_write(addi_inst(5'd0, 5'd0, 12'h000), 5'd0, 32'h0);
        end
    endtask

    task automatic build_program();
        alu_write(lu12i_inst(5'd1, 20'h12345), 5'd1, 32'h1234_5000);
        alu_write(addi_inst(5'd2, 5'd0, 12'h678), 5'd2, 32'h0000_0678);
        alu_write(addi_inst(5'd3, 5'd0, 12'hfff), 5'd3, 32'hffff_ffff);
        alu_write(addi_inst(5'd4, 5'd0, 12'h005), 5'd4, 32'h0000_0005);
        nops(3);
        // add, sub, slt, sltu, and, or, xor, nor
        alu_write(rrr_inst(5'h00, 5'd5, 5'd1, 5'd2), 5'd5, 32'h1234_5678);
        alu_write(rrr_inst(5'h02, 5'd6, 5'd4, 5'd3), 5'd6, 32'h0000_0006);
        alu_write(rrr_inst(5'h04, 5'd7, 5'd3, 5'd4), 5'd7, 32'h0000_0001);
        alu_write(rrr_inst(5'h05, 5'd8, 5'd3, 5'd4), 5'd8, 32'h0000_0000);
        alu_write(rrr_inst(5'h09, 5'd9, 5'd1, 5'd3), 5'd9, 32'h1234_5000);
        alu_write(rrr_inst(5'h0a, 5'd10, 5'd2, 5'd4), 5'd10, 32'h0000_067d);
        alu_write(rrr_inst(5'h0b, 5'd11, 5'd3, 5'd2), 5'd11, 32'hffff_f987);
        alu_write(rrr_inst(5'h08, 5'd12, 5'd2, 5'd4), 5'd12, 32'hffff_f982);
        // data base address
        alu_write(addi_inst(5'd13, 5'd0, 12'h100), 5'd13, 32'h0000_0100);
        // aimed at r0, trace shows the sum
        alu_write(addi_inst(5'd0, 5'd4, 12'h009), 5'd0, 32'h0000_000e);
        nops(3);
        store_write(ldst_inst(1'b1, 5'd5, 5'd13, 12'h008), 32'h0000_0108, 32'h1234_5678);
        // r0 must still read zero here
        alu_write(rrr_inst(5'h00, 5'd14, 5'd0, 5'd4), 5'd14, 32'h0000_0005);
        alu_write(ldst_inst(1'b0, 5'd15, 5'd13, 12'h008), 5'd15, 32'h1234_5678);
        nops(3);
        // taken beq skips two
        put(cond_branch_inst(6'h16, 5'd15, 5'd5, 16'd3), 1'b1);
        put(addi_inst(5'd16, 5'd0, 12'h001), 1'b1);
        put(addi_inst(5'd16, 5'd0, 12'h002), 1'b1);
        // not-taken bne falls through
        put(cond_branch_inst(6'h17, 5'd15, 5'd5, 16'd3), 1'b1);
        alu_write(addi_inst(5'd17, 5'd0, 12'h011), 5'd17, 32'h0000_0011);
        // not-taken beq
        put(cond_branch_inst(6'h16, 5'd3, 5'd4, 16'd2), 1'b1);
        alu_write(addi_inst(5'd18, 5'd0, 12'h022), 5'd18, 32'h0000_0022);
        // taken bne
        put(cond_branch_inst(6'h17, 5'd3, 5'd4, 16'd3), 1'b1);
        put(addi_inst(5'd19, 5'd0, 12'h033), 1'b1);
        put(addi_inst(5'd19, 5'd0, 12'h044), 1'b1);
        // unconditional b
        put(b_inst(26'd3), 1'b1);
        put(addi_inst(5'd20, 5'd0, 12'h055), 1'b1);
        put(addi_inst(5'd20, 5'd0, 12'h066), 1'b1);
        alu_write(addi_inst(5'd21, 5'd0, 12'hff8), 5'd21, 32'hffff_fff8);
        nops(3);
        store_write(ldst_inst(1'b1, 5'd21, 5'd13, 12'h00c), 32'h0000_010c, 32'hffff_fff8);
        alu_write(ldst_inst(1'b0, 5'd22, 5'd13, 12'h00c), 5'd22, 32'hffff_fff8);
        // halt on a branch to itself
        put(b_inst(26'd0), 1'b1);
    endtask

    // sync sram models, address taken at the edge, data driven on the falling edge
    always @(posedge clk) begin
        iaddr_q <= inst_sram_addr;
        daddr_q <= data_sram_addr;
        if (data_sram_we) begin
            ram[data_sram_addr[7:2]] <= data_sram_wdata;
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= rom_word(iaddr_q);
        data_sram_rdata <= ram[daddr_q[7:2]];
    end

    // walk the expected lists
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset && debug_wb_rf_we) begin
            trace_idx <= trace_idx + 1;
        end
        if (!reset && data_sram_we) begin
            store_idx <= store_idx + 1;
        end
    end

    assign want_pc    = exp_pc[trace_idx];
    assign want_wnum  = exp_wnum[trace_idx];
    assign want_wdata = exp_wdata[trace_idx];
    assign want_saddr = exp_saddr[store_idx];
    assign want_sdata = exp_sdata[store_idx];
    assign wb_index   = (debug_wb_pc - reset_vector) >> 2;
    assign wb_quiet   = (wb_index < prog_len) ? quiet[wb_index] : 1'b0;

    // first edge skipped, stages are not reset yet
    quiet_in_reset: assert property (@(posedge clk)
        reset && cycle > 0 |-> !debug_wb_rf_we)
        else note_mismatch("debug_wb_rf_we", 32'd0, {31'd0, $sampled(debug_wb_rf_we)});

    no_early_store: assert property (@(posedge clk)
        cycle > 0 && (reset || trace_idx == 0) |-> !data_sram_we)
        else note_mismatch("data_sram_we", 32'd0, {31'd0, $sampled(data_sram_we)});

    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> inst_sram_addr == reset_vector)
        else note_mismatch("inst_sram_addr", reset_vector, $sampled(inst_sram_addr));

    trace_bounded: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |-> trace_idx < trace_count)
        else raise_fault("register write traced past the end of the expected list");

    trace_pc: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we && trace_idx < trace_count |-> debug_wb_pc == want_pc)
        else note_mismatch("debug_wb_pc", $sampled(want_pc), $sampled(debug_wb_pc));

    trace_wnum: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we && trace_idx < trace_count |-> debug_wb_rf_wnum == want_wnum)
        else note_mismatch("debug_wb_rf_wnum", {27'd0, $sampled(want_wnum)},
                           {27'd0, $sampled(debug_wb_rf_wnum)});

    trace_wdata: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we && trace_idx < trace_count |-> debug_wb_rf_wdata == want_wdata)
        else note_mismatch("debug_wb_rf_wdata", $sampled(want_wdata),
                           $sampled(debug_wb_rf_wdata));

    // stores, branches and flushed words
    silent_pc: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |-> !wb_quiet)
        else raise_fault("a store, a branch or a flushed instruction wrote a register");

    store_bounded: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> store_idx < store_count)
        else raise_fault("data memory written more often than the program stores");

    store_addr: assert property (@(posedge clk) disable iff (reset)
        data_sram_we && store_idx < store_count |-> data_sram_addr == want_saddr)
        else note_mismatch("data_sram_addr", $sampled(want_saddr), $sampled(data_sram_addr));

    store_data: assert property (@(posedge clk) disable iff (reset)
        data_sram_we && store_idx < store_count |-> data_sram_wdata == want_sdata)
        else note_mismatch("data_sram_wdata", $sampled(want_sdata), $sampled(data_sram_wdata));

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        errors          = 0;
        cycle           = 0;
        trace_idx       = 0;
        store_idx       = 0;
        prog_len        = 0;
        trace_count     = 0;
        store_count     = 0;
        for (int a = 0; a < 64; a++) begin
            ram[a] = (32'(a) << 2) ^ 32'h5a5a_5a5a;
        end
        build_program();
        // 8 cycles of reset, released on a falling edge
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
        end
        reset = 1'b0;
        waited = 0;
        while (trace_idx < trace_count && waited < max_cycles) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (trace_idx < trace_count) begin
            raise_fault("program did not finish within the cycle limit");
        end
        // halt loop keeps running, a stray late write would still show
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
        end
        if (store_idx != store_count) begin
            raise_fault("not every expected store reached the data memory");
        end
        $display("errors %0d, trace writes %0d of %0d, stores %0d of %0d",
                 errors, trace_idx, trace_count, store_idx, store_count);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
cpu_pkg.sv
dmem_if.sv
regfile.sv
alu.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
cpu_core.sv
tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - dmem_if.sv
  - regfile.sv
  - alu.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - writeback_stage.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_cpu_core.sv
